//--- hdl/intr_pkg.sv
// Shared widths, register map and bus structs for the interrupt controller; import into RTL and TB
package intr_pkg;

  // Largest source count the controller can be built for
  localparam int MAX_SOURCES = 32;

  // Source identifier width, enough for MAX_SOURCES
  localparam int ID_W = 5;

  // Configuration write data width
  localparam int DATA_W = 32;

  // Register map, 2-bit word address
  // Enable mask, one bit per source
  localparam logic [1:0] ADDR_MASK = 2'd0;

  // Trigger mode, 1 selects rising edge, 0 selects level
  localparam logic [1:0] ADDR_EDGE = 2'd1;

  // Acknowledge, identifier in the low ID_W bits of the data
  localparam logic [1:0] ADDR_ACK = 2'd2;

  // Software trigger, each set bit fires that source's edge latch
  localparam logic [1:0] ADDR_TRIG = 2'd3;

  // One configuration write, stb is a single-cycle strobe
  typedef struct packed {
    logic              stb;
    logic [1:0]        addr;
    logic [DATA_W-1:0] data;
  } cfg_req_t;

  // Acknowledge strobe with the identifier being retired
  typedef struct packed {
    logic            stb;
    logic [ID_W-1:0] id;
  } ack_t;

  // Priority encoder result
  typedef struct packed {
    logic            valid;
    logic [ID_W-1:0] id;
  } grant_t;

endpackage

//--- hdl/intr_reg_decode.sv
// Register write decoder holding the enable mask and trigger mode, and issuing ack and trig strobes
`timescale 1ns/1ns

module intr_reg_decode #(
  parameter int SOURCES = intr_pkg::MAX_SOURCES
) (
  input  logic               clk,
  input  logic               rst,
  input  intr_pkg::cfg_req_t cfg,
  output logic [SOURCES-1:0] mask,
  output logic [SOURCES-1:0] edge_sel,
  output logic [SOURCES-1:0] trig,
  output intr_pkg::ack_t     ack
);

  import intr_pkg::*;

  logic            ack_stb;
  logic [ID_W-1:0] ack_id;

  // Mask and mode take the new value on the strobe edge
  // Trig and ack are one-cycle pulses issued in the cycle after the write
  always_ff @(posedge clk) begin
    if (rst) begin
      mask     <= '0;
      edge_sel <= '0;
      trig     <= '0;
      ack_stb  <= 1'b0;
    end else begin
      trig    <= '0;
      ack_stb <= 1'b0;
      if (cfg.stb) begin
        case (cfg.addr)
          ADDR_MASK: begin
            mask <= cfg.data[SOURCES-1:0];
          end
          ADDR_EDGE: begin
            edge_sel <= cfg.data[SOURCES-1:0];
          end
          ADDR_ACK: begin
            ack_stb <= 1'b1;
          end
          ADDR_TRIG: begin
            trig <= cfg.data[SOURCES-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Identifier only matters when ack_stb is high
  always_ff @(posedge clk) begin
    ack_id <= cfg.data[ID_W-1:0];
  end

  assign ack = '{stb: ack_stb, id: ack_id};

  // An emitted ack names a real source
  a_ack_in_range: assert property (@(posedge clk) disable iff (rst)
    ack.stb |-> (ack.id < SOURCES))
    else $error("ack identifier %0d out of range", ack.id);

endmodule

//--- hdl/intr_source_capture.sv
// Source sampling, rising-edge latches and masked pending vector feeding the priority encoder
`timescale 1ns/1ns

module intr_source_capture #(
  parameter int SOURCES = intr_pkg::MAX_SOURCES
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [SOURCES-1:0] sources,
  input  logic [SOURCES-1:0] mask,
  input  logic [SOURCES-1:0] edge_sel,
  input  logic [SOURCES-1:0] trig,
  input  intr_pkg::ack_t     ack,
  output logic [SOURCES-1:0] req
);

  import intr_pkg::*;

  localparam logic [SOURCES-1:0] ONE = SOURCES'(1);

  // Input sample stage
  logic [SOURCES-1:0] src_q;
  logic [SOURCES-1:0] src_prev;
  logic [SOURCES-1:0] mask_q;
  logic [SOURCES-1:0] edge_q;
  logic [SOURCES-1:0] trig_q;
  logic               ack_stb_q;
  logic [ID_W-1:0]    ack_id_q;

  logic [SOURCES-1:0] latch;
  logic [SOURCES-1:0] rise;
  logic [SOURCES-1:0] clr;
  logic [SOURCES-1:0] set;
  logic [SOURCES-1:0] latch_nxt;
  logic [SOURCES-1:0] pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      src_q     <= '0;
      src_prev  <= '0;
      mask_q    <= '0;
      edge_q    <= '0;
      trig_q    <= '0;
      ack_stb_q <= 1'b0;
      latch     <= '0;
      req       <= '0;
    end else begin
      src_q     <= sources;
      src_prev  <= src_q;
      mask_q    <= mask;
      edge_q    <= edge_sel;
      trig_q    <= trig;
      ack_stb_q <= ack.stb;
      latch     <= latch_nxt;
      req       <= pend & mask_q;
    end
  end

  always_ff @(posedge clk) begin
    ack_id_q <= ack.id;
  end

  always_comb begin
    rise = src_q & ~src_prev;
    clr  = ack_stb_q ? (ONE << ack_id_q) : '0;
    set  = rise | trig_q;
    // Set beats clear; latches of level-mode sources are held empty
    latch_nxt = ((latch & ~clr) | set) & edge_q;
    pend      = latch_nxt | (src_q & ~edge_q);
  end

endmodule

//--- hdl/intr_prio_encoder.sv
// Three-stage split-half priority encoder, upper half wins and lowest index wins within a half
`timescale 1ns/1ns

module intr_prio_encoder #(
  parameter int SOURCES = intr_pkg::MAX_SOURCES
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [SOURCES-1:0] req,
  output intr_pkg::grant_t   grant
);

  import intr_pkg::*;

  localparam int HALF = SOURCES / 2;

  // Stage 1
  logic [SOURCES-1:0] req_s1;
  logic               any_s1;

  // Stage 2
  logic               any_s2;
  logic               up_hit_s2;
  logic [ID_W-1:0]    up_id_s2;
  logic [ID_W-1:0]    lo_id_s2;

  // Stage 3
  logic               grant_valid;
  logic [ID_W-1:0]    grant_id;

  logic               up_hit;
  logic [ID_W-1:0]    up_id;
  logic [ID_W-1:0]    lo_id;

  always_ff @(posedge clk) begin
    if (rst) begin
      any_s1      <= 1'b0;
      any_s2      <= 1'b0;
      grant_valid <= 1'b0;
    end else begin
      any_s1      <= |req;
      any_s2      <= any_s1;
      grant_valid <= any_s2;
    end
  end

  // Both halves searched in parallel, scanning down so the lowest set bit wins
  always_comb begin
    up_hit = 1'b0;
    up_id  = '0;
    lo_id  = '0;
    for (int i = SOURCES - 1; i >= HALF; i--) begin
      if (req_s1[i]) begin
        up_hit = 1'b1;
        up_id  = ID_W'(i);
      end
    end
    for (int j = HALF - 1; j >= 0; j--) begin
      if (req_s1[j]) begin
        lo_id = ID_W'(j);
      end
    end
  end

  always_ff @(posedge clk) begin
    req_s1    <= req;
    up_hit_s2 <= up_hit;
    up_id_s2  <= up_id;
    lo_id_s2  <= lo_id;
    // Any upper-half request takes precedence
    grant_id  <= up_hit_s2 ? up_id_s2 : lo_id_s2;
  end

  assign grant = '{valid: grant_valid, id: grant_id};

  // A valid grant names a real source that was requesting three cycles earlier
  a_grant_source: assert property (@(posedge clk) disable iff (rst)
    grant.valid |-> ((grant.id < SOURCES) &&
                     (|($past(req, 3) & (SOURCES'(1) << grant.id)))))
    else $error("grant id %0d out of range or not requested", grant.id);

endmodule

//--- hdl/intr_claim_unit.sv
// Interrupt output register with post-acknowledge blanking while the capture and encoder flush
`timescale 1ns/1ns

module intr_claim_unit #(
  parameter int SOURCES = intr_pkg::MAX_SOURCES
) (
  input  logic                    clk,
  input  logic                    rst,
  input  intr_pkg::grant_t        grant,
  input  intr_pkg::ack_t          ack,
  output logic                    irq,
  output logic [intr_pkg::ID_W-1:0] irq_id
);

  import intr_pkg::*;

  // Capture stage plus encoder depth
  localparam int BLANK_CYCLES = 4;
  localparam int CNT_W        = $clog2(BLANK_CYCLES + 1);

  logic [CNT_W-1:0] blank_cnt;
  logic             blank;

  // Stale grants from before the ack are still in the pipe
  assign blank = ack.stb || (blank_cnt != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      blank_cnt <= '0;
      irq       <= 1'b0;
    end else begin
      if (ack.stb) begin
        blank_cnt <= CNT_W'(BLANK_CYCLES);
      end else if (blank_cnt != '0) begin
        blank_cnt <= blank_cnt - 1'b1;
      end
      irq <= grant.valid && !blank;
    end
  end

  always_ff @(posedge clk) begin
    irq_id <= grant.id;
  end

  // No interrupt is presented inside the blanking window
  a_blank_low: assert property (@(posedge clk) disable iff (rst)
    (blank_cnt != '0) |-> !irq)
    else $error("irq high during blanking window");

endmodule

//--- hdl/intr_ctrl_top.sv
// Interrupt controller top, connects register decode, source capture, encoder and claim unit
`timescale 1ns/1ns

module intr_ctrl_top #(
  parameter int SOURCES = intr_pkg::MAX_SOURCES
) (
  input  logic                      clk,
  input  logic                      rst,
  input  intr_pkg::cfg_req_t        cfg,
  input  logic [SOURCES-1:0]        sources,
  output logic                      irq,
  output logic [intr_pkg::ID_W-1:0] irq_id
);

  import intr_pkg::*;

  logic [SOURCES-1:0] mask;
  logic [SOURCES-1:0] edge_sel;
  logic [SOURCES-1:0] trig;
  logic [SOURCES-1:0] req;
  ack_t               ack;
  grant_t             grant;

  intr_reg_decode #(.SOURCES(SOURCES)) u_decode (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .mask     (mask),
    .edge_sel (edge_sel),
    .trig     (trig),
    .ack      (ack)
  );

  intr_source_capture #(.SOURCES(SOURCES)) u_capture (
    .clk      (clk),
    .rst      (rst),
    .sources  (sources),
    .mask     (mask),
    .edge_sel (edge_sel),
    .trig     (trig),
    .ack      (ack),
    .req      (req)
  );

  intr_prio_encoder #(.SOURCES(SOURCES)) u_encoder (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .grant (grant)
  );

  intr_claim_unit #(.SOURCES(SOURCES)) u_claim (
    .clk    (clk),
    .rst    (rst),
    .grant  (grant),
    .ack    (ack),
    .irq    (irq),
    .irq_id (irq_id)
  );

endmodule

//--- tb/intr_ctrl_tb.sv
// Self-checking testbench for the interrupt controller, run as the simulation top with compile.f
`timescale 1ns/1ns

module intr_ctrl_tb;

  import intr_pkg::*;

  localparam int SOURCES     = 32;
  localparam int HALF        = SOURCES / 2;
  localparam int SETTLE      = 10;
  localparam int RAND_ROUNDS = 200;
  // About 30 cycles per random round plus the directed tests, with ample margin
  localparam int CYCLE_LIMIT = 20000;

  logic               clk;
  logic               rst;
  cfg_req_t           cfg;
  logic [SOURCES-1:0] sources;
  logic               irq;
  logic [ID_W-1:0]    irq_id;

  // Reference state, updated from what the testbench drives
  logic [SOURCES-1:0] m_mask;
  logic [SOURCES-1:0] m_mode;
  logic [SOURCES-1:0] m_latch;
  logic [SOURCES-1:0] m_src;

  logic            exp_irq;
  logic [ID_W-1:0] exp_id;
  logic [31:0]     lfsr;
  int              err_count;
  int              check_count;
  int              errs_at_start;
  int              tests_run;
  int              tests_failed;
  int              cycles;
  event            check_req;
  event            check_done;

  intr_ctrl_top #(.SOURCES(SOURCES)) u_dut (
    .clk     (clk),
    .rst     (rst),
    .cfg     (cfg),
    .sources (sources),
    .irq     (irq),
    .irq_id  (irq_id)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, the tests did not complete", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Upper half beats lower half, lowest index wins inside a half
  function automatic grant_t ref_grant(input logic [SOURCES-1:0] pend);
    grant_t g;
    g = '0;
    for (int i = HALF; i < SOURCES; i++) begin
      if (pend[i] && !g.valid) begin
        g.valid = 1'b1;
        g.id    = ID_W'(i);
      end
    end
    for (int i = 0; i < HALF; i++) begin
      if (pend[i] && !g.valid) begin
        g.valid = 1'b1;
        g.id    = ID_W'(i);
      end
    end
    return g;
  endfunction

  // One step of the Galois LFSR
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  // Waits for the pipeline to settle, then checks the outputs
  always begin
    @(check_req);
    repeat (SETTLE) @(posedge clk);
    @(negedge clk);
    check_count++;
    if (irq !== exp_irq) begin
      $display("[FAIL] %0t irq got %0b expected %0b", $time, irq, exp_irq);
      err_count++;
    end else if (exp_irq && (irq_id !== exp_id)) begin
      $display("[FAIL] %0t irq_id got %0d expected %0d", $time, irq_id, exp_id);
      err_count++;
    end
    -> check_done;
  end

  task automatic settle_and_compare;
    logic [SOURCES-1:0] pend;
    grant_t             g;
    pend    = ((m_latch & m_mode) | (m_src & ~m_mode)) & m_mask;
    g       = ref_grant(pend);
    exp_irq = g.valid;
    exp_id  = g.id;
    -> check_req;
    @(check_done);
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk);
    cfg = '{stb: 1'b1, addr: addr, data: data};
    @(negedge clk);
    cfg = '0;
  endtask

  task automatic set_mask(input logic [SOURCES-1:0] v);
    cfg_write(ADDR_MASK, DATA_W'(v));
    m_mask = v;
  endtask

  // Leaving edge mode empties that source's latch
  task automatic set_mode(input logic [SOURCES-1:0] v);
    cfg_write(ADDR_EDGE, DATA_W'(v));
    m_mode  = v;
    m_latch = m_latch & v;
  endtask

  task automatic sw_trigger(input logic [SOURCES-1:0] v);
    cfg_write(ADDR_TRIG, DATA_W'(v));
    m_latch = m_latch | (v & m_mode);
  endtask

  task automatic send_ack(input logic [ID_W-1:0] id);
    cfg_write(ADDR_ACK, DATA_W'(id));
    m_latch[id] = 1'b0;
  endtask

  task automatic drive_sources(input logic [SOURCES-1:0] v);
    @(negedge clk);
    m_latch = m_latch | (v & ~m_src & m_mode);
    m_src   = v;
    sources = v;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_count == errs_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  initial begin
    logic [31:0] r_mode;
    logic [31:0] r_mask;
    logic [31:0] r_src;
    clk = 1'b0;
    rst = 1'b1;
    cfg = '0;
    sources = '0;
    m_mask = '0;
    m_mode = '0;
    m_latch = '0;
    m_src = '0;
    lfsr = 32'h5e4d;
    err_count = 0;
    check_count = 0;
    errs_at_start = 0;
    tests_run = 0;
    tests_failed = 0;
    cycles = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    settle_and_compare();
    set_mask('1);
    settle_and_compare();
    report_test("reset and idle");

    drive_sources((1 << 3) | (1 << 20));
    settle_and_compare();
    drive_sources((1 << 3) | (1 << 9));
    settle_and_compare();
    drive_sources((1 << 17) | (1 << 30));
    settle_and_compare();
    report_test("level priority");

    drive_sources((1 << 3) | (1 << 20));
    set_mask(~(SOURCES'(1) << 20));
    settle_and_compare();
    set_mask('0);
    settle_and_compare();
    report_test("masking");

    set_mask('1);
    drive_sources('0);
    set_mode(1 << 7);
    // One-cycle pulse must be held by the edge latch
    drive_sources(1 << 7);
    drive_sources('0);
    settle_and_compare();
    send_ack(5'd7);
    settle_and_compare();
    report_test("edge latch and ack");

    set_mode(1 << 12);
    sw_trigger(1 << 12);
    settle_and_compare();
    send_ack(5'd12);
    settle_and_compare();
    sw_trigger(1 << 5);
    settle_and_compare();
    report_test("software trigger");

    for (int r = 0; r < RAND_ROUNDS; r++) begin
      take_bits(32, r_mode);
      take_bits(32, r_mask);
      take_bits(32, r_src);
      set_mode(r_mode);
      set_mask(r_mask);
      drive_sources(r_src);
      settle_and_compare();
      if (exp_irq) begin
        send_ack(exp_id);
        settle_and_compare();
      end
    end
    report_test("random rounds");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/intr_pkg.sv
hdl/intr_reg_decode.sv
hdl/intr_source_capture.sv
hdl/intr_prio_encoder.sv
hdl/intr_claim_unit.sv
hdl/intr_ctrl_top.sv
tb/intr_ctrl_tb.sv

//--- Makefile
# Verilator simulation of the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= intr_ctrl_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
